/* run_sim.sh */
#!/usr/bin/env bash
# Builds the UMI split testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f umi_split.f --top-module umi_split_tb -Mdir obj_dir
./obj_dir/Vumi_split_tb | tee "$LOG"

if grep -qx "NO ERRORS" "$LOG"; then
   echo "Simulation passed"
else
   echo "Simulation failed, see $LOG"
   exit 1
fi

/* src/umi_config.svh */
// UMI packet widths and field positions, included wherever the packet layout is needed
`ifndef UMI_CONFIG_SVH
`define UMI_CONFIG_SVH

//####################
// Widths
//####################
`define UMI_AW      64                   // Address width
`define UMI_UW      256                  // Full packet width
`define UMI_CMD_W   8                    // Command byte
`define UMI_SIZE_W  4                    // Transfer size code
`define UMI_OPT_W   20                   // Options field
`define UMI_DATA_W  96                   // Payload bits left after header

//####################
// Field LSBs, command sits in the top byte
//####################
`define UMI_DATA_LSB  0
`define UMI_SRC_LSB   (`UMI_DATA_LSB + `UMI_DATA_W)
`define UMI_DST_LSB   (`UMI_SRC_LSB + `UMI_AW)
`define UMI_OPT_LSB   (`UMI_DST_LSB + `UMI_AW)
`define UMI_SIZE_LSB  (`UMI_OPT_LSB + `UMI_OPT_W)
`define UMI_CMD_LSB   (`UMI_SIZE_LSB + `UMI_SIZE_W)

`endif

/* src/umi_pipe_stage.sv */
// Two-entry UMI register slice with registered ready, used at the input and on each output
`timescale 1ns/100ps
`default_nettype none

module umi_pipe_stage (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 in_valid,
   input  umi_pkg::umi_packet_t in_packet,
   output logic                 in_ready,
   output logic                 out_valid,
   output umi_pkg::umi_packet_t out_packet,
   input  logic                 out_ready
);

   import umi_pkg::*;

   // Occupancy of the slice
   typedef enum logic [1:0] {ST_EMPTY, ST_ONE, ST_TWO} stage_state_e;

   stage_state_e state;
   stage_state_e state_n;
   umi_packet_t  main_packet;            // Head, drives the output
   umi_packet_t  spare_packet;           // Skid entry caught during a stall
   logic         ready_q;
   logic         push;
   logic         pop;

   assign push       = in_valid & ready_q;
   assign pop        = out_valid & out_ready;
   assign in_ready   = ready_q;
   assign out_valid  = (state != ST_EMPTY);
   assign out_packet = main_packet;

   //####################
   // Occupancy FSM
   //####################
   always_comb begin
      state_n = state;
      case (state)
         ST_EMPTY: if (push) state_n = ST_ONE;
         ST_ONE: begin
            if (push & ~pop) state_n = ST_TWO;           // Stall, spare fills
            else if (~push & pop) state_n = ST_EMPTY;
         end
         ST_TWO: if (pop) state_n = ST_ONE;              // Spare moves to head
         default: state_n = ST_EMPTY;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ST_EMPTY;
         ready_q <= 1'b1;                // Empty, so accept at once
      end else begin
         state   <= state_n;
         ready_q <= (state_n != ST_TWO); // Drops only once both entries hold
      end
   end

   //####################
   // Payload registers
   //####################
   always_ff @(posedge clk) begin
      if (state == ST_TWO) begin
         if (pop) main_packet <= spare_packet;
      end else if (push & ((state == ST_EMPTY) | pop)) begin
         main_packet <= in_packet;       // Head free or leaving this edge
      end
      if (push & (state == ST_ONE) & ~pop) spare_packet <= in_packet;
   end

endmodule

`default_nettype wire

/* src/umi_pkg.sv */
// UMI packet, decoded field and opcode types, imported by every module of the splitter
`default_nettype none

`include "umi_config.svh"

package umi_pkg;

   //####################
   // Command opcodes
   //####################
   // Write class keeps bit 0 set, requests keep it clear
   typedef enum logic [`UMI_CMD_W-1:0] {
      UMI_NOP          = 8'h00,
      UMI_READ         = 8'h02,          // Read request
      UMI_WRITE        = 8'h01,          // Acked write
      UMI_WRITE_POSTED = 8'h03,          // Write, no response
      UMI_ATOMIC       = 8'h04,          // Read-modify-write request
      UMI_RESP_READ    = 8'h05,          // Read data coming back
      UMI_RESP_WRITE   = 8'h07           // Write ack coming back
   } umi_opcode_e;

   //####################
   // Packet layout
   //####################
   // First member is the MSB end, total is UMI_UW
   typedef struct packed {
      logic [`UMI_CMD_W-1:0]  command;   // Raw byte, may hold unknown codes
      logic [`UMI_SIZE_W-1:0] size;
      logic [`UMI_OPT_W-1:0]  options;
      logic [`UMI_AW-1:0]     dstaddr;
      logic [`UMI_AW-1:0]     srcaddr;
      logic [`UMI_DATA_W-1:0] data;
   } umi_packet_t;

   // Decoded view produced by umi_unpack
   typedef struct packed {
      umi_opcode_e            opcode;
      logic [`UMI_SIZE_W-1:0] size;
      logic                   write;     // Goes to the response channel
   } umi_fields_t;

endpackage

`default_nettype wire

/* src/umi_split_top.sv */
// UMI split subsystem top, input slice into the splitter and one slice per output channel
`timescale 1ns/100ps
`default_nettype none

module umi_split_top (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 in_valid,
   input  umi_pkg::umi_packet_t in_packet,
   output logic                 in_ready,
   output logic                 resp_out_valid,
   output umi_pkg::umi_packet_t resp_out_packet,
   input  logic                 resp_out_ready,
   output logic                 req_out_valid,
   output umi_pkg::umi_packet_t req_out_packet,
   input  logic                 req_out_ready
);

   import umi_pkg::*;

   // Input slice to splitter
   logic        split_valid;
   umi_packet_t split_packet;
   logic        split_ready;

   // Splitter to output slices
   logic        resp_valid;
   umi_packet_t resp_packet;
   logic        resp_ready;
   logic        req_valid;
   umi_packet_t req_packet;
   logic        req_ready;

   //####################
   // Input side
   //####################
   umi_pipe_stage in_stage (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_packet  (in_packet),
      .in_ready   (in_ready),
      .out_valid  (split_valid),
      .out_packet (split_packet),
      .out_ready  (split_ready)
   );

   umi_splitter splitter (
      .in_valid    (split_valid),
      .in_packet   (split_packet),
      .in_ready    (split_ready),
      .resp_valid  (resp_valid),
      .req_valid   (req_valid),
      .resp_packet (resp_packet),
      .req_packet  (req_packet),
      .resp_ready  (resp_ready),
      .req_ready   (req_ready)
   );

   //####################
   // Output side
   //####################
   umi_pipe_stage resp_stage (         // Writes and responses
      .clk        (clk),
      .reset      (reset),
      .in_valid   (resp_valid),
      .in_packet  (resp_packet),
      .in_ready   (resp_ready),
      .out_valid  (resp_out_valid),
      .out_packet (resp_out_packet),
      .out_ready  (resp_out_ready)
   );

   umi_pipe_stage req_stage (          // Reads, atomics, everything else
      .clk        (clk),
      .reset      (reset),
      .in_valid   (req_valid),
      .in_packet  (req_packet),
      .in_ready   (req_ready),
      .out_valid  (req_out_valid),
      .out_packet (req_out_packet),
      .out_ready  (req_out_ready)
   );

endmodule

`default_nettype wire

/* src/umi_splitter.sv */
// UMI traffic splitter, sends write-class packets to the response side and the rest to requests
`timescale 1ns/100ps
`default_nettype none

module umi_splitter (
   input  logic                 in_valid,
   input  umi_pkg::umi_packet_t in_packet,
   output logic                 in_ready,
   output logic                 resp_valid,
   output logic                 req_valid,
   output umi_pkg::umi_packet_t resp_packet,
   output umi_pkg::umi_packet_t req_packet,
   input  logic                 resp_ready,
   input  logic                 req_ready
);

   import umi_pkg::*;

   umi_fields_t fields;                  // Decoded view of the input

   //####################
   // Decode
   //####################
   umi_unpack unpack (
      .packet (in_packet),
      .fields (fields)
   );

   // Valid qualified by class, one side only
   assign resp_valid = in_valid & fields.write;
   assign req_valid  = in_valid & ~fields.write;

   // Same packet offered to both sides
   assign resp_packet = in_packet;
   assign req_packet  = in_packet;

   //####################
   // Blocking ready
   //####################
   // Stall only on the side this packet targets
   assign in_ready = ~(resp_valid & ~resp_ready) &
                     ~(req_valid & ~req_ready);

endmodule

`default_nettype wire

/* src/umi_unpack.sv */
// Combinational UMI decoder, splits a packet into fields and flags write-class opcodes
`timescale 1ns/100ps
`default_nettype none

module umi_unpack (
   input  umi_pkg::umi_packet_t packet,
   output umi_pkg::umi_fields_t fields
);

   import umi_pkg::*;

   umi_opcode_e opcode;                  // Command byte as an opcode
   logic        write;

   assign opcode = umi_opcode_e'(packet.command);

   //####################
   // Write class decode
   //####################
   // Single home of the routing rule
   always_comb begin
      case (opcode)
         UMI_WRITE,
         UMI_WRITE_POSTED,
         UMI_RESP_READ,
         UMI_RESP_WRITE: write = 1'b1;
         // Reads, atomics, NOP and unknown codes
         default: write = 1'b0;
      endcase
   end

   //####################
   // Field output
   //####################
   always_comb begin
      fields        = '0;
      fields.opcode = opcode;
      fields.size   = packet.size;       // Passed through untouched
      fields.write  = write;
   end

endmodule

`default_nettype wire

/* umi_split.f */
+incdir+src
src/umi_pkg.sv
src/umi_unpack.sv
src/umi_pipe_stage.sv
src/umi_splitter.sv
src/umi_split_top.sv
verification/umi_split_checker.sv
verification/umi_split_tb.sv

/* verification/umi_split_checker.sv */
// Monitor for the UMI split DUT, predicts each packet's route and compares both outputs in order
`timescale 1ns/100ps
`default_nettype none

module umi_split_checker (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 in_valid,
   input  umi_pkg::umi_packet_t in_packet,
   input  logic                 in_route_resp,   // Expected route of the packet on in
   input  logic                 in_ready,
   input  logic                 resp_out_valid,
   input  umi_pkg::umi_packet_t resp_out_packet,
   input  logic                 resp_out_ready,
   input  logic                 req_out_valid,
   input  umi_pkg::umi_packet_t req_out_packet,
   input  logic                 req_out_ready,
   input  logic                 strict_timing,   // Burst mode, ready and latency fixed
   output int                   error_count,
   output int                   resp_pending,
   output int                   req_pending
);

   import umi_pkg::*;

   umi_packet_t resp_q[$];               // Expected resp_out order
   umi_packet_t req_q[$];
   int          resp_time_q[$];          // Acceptance edge of each entry
   int          req_time_q[$];
   int          cycle;
   logic        first_after_reset;
   umi_packet_t expected;
   int          accepted;

   // Compares one output transfer with its prediction
   task automatic check_packet(input string side, input umi_packet_t got,
                               input umi_packet_t exp_pkt, input int acc_cycle);
      if (got !== exp_pkt) begin
         $display("Fail %0t: %0s packet %h, expected %h", $time, side, got, exp_pkt);
         error_count++;
      end else if (strict_timing && (cycle - acc_cycle != 2)) begin
         $display("Fail %0t: %0s latency %0d edges, expected 2", $time, side, cycle - acc_cycle);
         error_count++;
      end
   endtask

   //####################
   // Sampling at each edge
   //####################
   always @(posedge clk) begin
      cycle = cycle + 1;
      if (reset) begin
         first_after_reset = 1'b1;
         resp_q.delete();
         req_q.delete();
      end else begin
         if (first_after_reset && (resp_out_valid || req_out_valid || !in_ready)) begin
            $display("Fail %0t: after reset valids %b %b, in_ready %b", $time,
                     resp_out_valid, req_out_valid, in_ready);
            error_count++;
         end
         first_after_reset = 1'b0;
         if (resp_out_valid && resp_out_ready) begin
            if (resp_q.size() == 0) begin
               $display("Unexpected packet on resp_out at %0t with nothing pending", $time);
               error_count++;
            end else begin
               expected = resp_q.pop_front();
               accepted = resp_time_q.pop_front();
               check_packet("resp_out", resp_out_packet, expected, accepted);
            end
         end
         if (req_out_valid && req_out_ready) begin
            if (req_q.size() == 0) begin
               $display("Unexpected packet on req_out at %0t with nothing pending", $time);
               error_count++;
            end else begin
               expected = req_q.pop_front();
               accepted = req_time_q.pop_front();
               check_packet("req_out", req_out_packet, expected, accepted);
            end
         end
         if (strict_timing && in_valid && !in_ready) begin
            $display("Fail %0t: in_ready low during back-to-back burst", $time);
            error_count++;
         end
         if (in_valid && in_ready) begin   // Accepted, queue by route
            if (in_route_resp) begin
               resp_q.push_back(in_packet);
               resp_time_q.push_back(cycle);
            end else begin
               req_q.push_back(in_packet);
               req_time_q.push_back(cycle);
            end
         end
      end
      resp_pending = resp_q.size();
      req_pending  = req_q.size();
   end

endmodule

`default_nettype wire

/* verification/umi_split_tb.sv */
// Testbench for the UMI split subsystem, applies a packet table under several back-pressure modes
`timescale 1ns/100ps
`default_nettype none

`include "umi_config.svh"

module umi_split_tb;

   import umi_pkg::*;

   localparam int TABLE_LEN   = 24;
   localparam int CLK_NS      = 40;
   localparam int RESET_CYC   = 16;
   localparam int TIMEOUT_NS  = TABLE_LEN * 40 * CLK_NS + RESET_CYC * CLK_NS;
   localparam int DRAIN_LIMIT = 200;     // Edges for the outputs to empty
   localparam int STALL_LIMIT = 20;

   typedef struct packed {
      umi_packet_t packet;
      logic        to_resp;              // Expected route
   } stim_t;

   logic        clk, reset, in_valid, in_ready, in_route_resp;
   logic        resp_out_valid, resp_out_ready, req_out_valid, req_out_ready;
   umi_packet_t in_packet, resp_out_packet, req_out_packet;
   logic        strict_timing;
   logic [1:0]  bp_mode;                 // 0 open, 1 random, 2 resp held, 3 req held
   logic [31:0] lfsr_state;
   logic [7:0]  opcode_list [8];
   stim_t       stim [TABLE_LEN];
   int          tb_errors, chk_errors, resp_pending, req_pending, last_errors, tests_run;

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Write class goes to the response side
   function automatic logic goes_to_resp(input logic [7:0] cmd);
      case (cmd)
         UMI_WRITE, UMI_WRITE_POSTED, UMI_RESP_READ, UMI_RESP_WRITE: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic int next_write(input int from);
      int i;
      i = from % TABLE_LEN;
      while (!stim[i].to_resp) i = (i + 1) % TABLE_LEN;
      return i;
   endfunction

   umi_split_top UUT (
      .clk (clk), .reset (reset),
      .in_valid (in_valid), .in_packet (in_packet), .in_ready (in_ready),
      .resp_out_valid (resp_out_valid), .resp_out_packet (resp_out_packet),
      .resp_out_ready (resp_out_ready),
      .req_out_valid (req_out_valid), .req_out_packet (req_out_packet),
      .req_out_ready (req_out_ready)
   );

   umi_split_checker check_unit (
      .clk (clk), .reset (reset),
      .in_valid (in_valid), .in_packet (in_packet), .in_route_resp (in_route_resp),
      .in_ready (in_ready),
      .resp_out_valid (resp_out_valid), .resp_out_packet (resp_out_packet),
      .resp_out_ready (resp_out_ready),
      .req_out_valid (req_out_valid), .req_out_packet (req_out_packet),
      .req_out_ready (req_out_ready), .strict_timing (strict_timing),
      .error_count (chk_errors), .resp_pending (resp_pending), .req_pending (req_pending)
   );

   always #(CLK_NS / 2) clk = ~clk;

   //####################
   // Output back-pressure
   //####################
   always @(posedge clk) begin
      if (bp_mode == 2'd1) begin
         lfsr_state = lfsr_step(lfsr_state);
         resp_out_ready <= lfsr_state[0];
         lfsr_state = lfsr_step(lfsr_state);
         req_out_ready <= lfsr_state[0];
      end else begin
         resp_out_ready <= (bp_mode != 2'd2);
         req_out_ready  <= (bp_mode != 2'd3);
      end
   end

   // Holds one table entry on in until taken
   task automatic send_entry(input int idx);
      in_valid      <= 1'b1;
      in_packet     <= stim[idx].packet;
      in_route_resp <= stim[idx].to_resp;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic send_table(input logic only_resp);
      for (int i = 0; i < TABLE_LEN; i++) begin
         if (!only_resp || stim[i].to_resp) send_entry(i);
      end
   endtask

   // Pending counts sampled at the falling edge after the checker's update
   task automatic wait_drained(input logic with_resp);
      int edges;
      edges = 0;
      @(negedge clk);
      while (((with_resp && resp_pending != 0) || req_pending != 0) && edges < DRAIN_LIMIT) begin
         @(negedge clk);
         edges++;
      end
      if ((with_resp && resp_pending != 0) || req_pending != 0) begin
         $display("Packets never left the DUT, resp %0d req %0d still pending",
                  resp_pending, req_pending);
         tb_errors++;
      end
      @(posedge clk);
   endtask

   task automatic finish_test(input string name);
      @(negedge clk);
      tests_run++;
      $display("Test %0s done, %0d errors", name, tb_errors + chk_errors - last_errors);
      last_errors = tb_errors + chk_errors;
      @(posedge clk);
   endtask

   // Two writes block the resp side before the requests, then writes run into the stall
   task automatic run_blocking();
      int   idx;
      int   edges;
      logic stalled;
      bp_mode <= 2'd2;
      repeat (2) @(posedge clk);
      idx = next_write(0);
      for (int n = 0; n < 2; n++) begin            // Resp slice full after these
         send_entry(idx);
         idx = next_write(idx + 1);
      end
      for (int i = 0; i < 6; i++) begin            // Requests behind a blocked resp side
         if (!stim[i].to_resp) send_entry(i);
      end
      edges   = 0;
      stalled = 1'b0;
      while (!stalled && edges < STALL_LIMIT) begin
         in_valid      <= 1'b1;
         in_packet     <= stim[idx].packet;
         in_route_resp <= 1'b1;
         @(posedge clk);
         edges++;
         if (!in_ready) stalled = 1'b1;          // Entry idx still on in
         else idx = next_write(idx + 1);
      end
      if (!stalled) begin
         $display("in_ready never fell with resp_out held off");
         tb_errors++;
      end
      wait_drained(1'b0);                          // Requests get out during the stall
      bp_mode <= 2'd0;
      send_entry(idx);
      wait_drained(1'b1);
   endtask

   //####################
   // Main sequence
   //####################
   initial begin
      clk            = 1'b0;
      reset          = 1'b1;
      in_valid       = 1'b0;
      in_packet      = '0;
      in_route_resp  = 1'b0;
      resp_out_ready = 1'b1;
      req_out_ready  = 1'b1;
      strict_timing  = 1'b0;
      bp_mode        = 2'd0;
      lfsr_state     = 32'h4178_2214;
      opcode_list    = '{UMI_NOP, UMI_READ, UMI_WRITE, UMI_WRITE_POSTED,
                         UMI_ATOMIC, UMI_RESP_READ, UMI_RESP_WRITE, 8'h3C};
      for (int i = 0; i < TABLE_LEN; i++) begin     // Stride 5 mixes the opcodes
         stim[i].packet.command = opcode_list[(i * 5) % 8];
         stim[i].packet.size    = 4'(i);
         stim[i].packet.options = 20'(i * 4369);
         stim[i].packet.dstaddr = {32'hD000_0000, 32'(i) * 32'h0101_0101};
         stim[i].packet.srcaddr = {32'h5000_0000 + 32'(i), 32'hA5A5_0000 ^ 32'(i)};
         stim[i].packet.data    = {32'(i) ^ 32'hC3C3_1000, ~32'(i), 32'(i) * 32'h1357};
         stim[i].to_resp        = goes_to_resp(stim[i].packet.command);
      end
      repeat (RESET_CYC) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      finish_test("reset_state");
      send_table(1'b0);
      wait_drained(1'b1);
      finish_test("routing");
      strict_timing <= 1'b1;
      send_table(1'b0);
      wait_drained(1'b1);
      strict_timing <= 1'b0;
      finish_test("throughput");
      bp_mode <= 2'd1;
      send_table(1'b0);
      bp_mode <= 2'd0;
      wait_drained(1'b1);
      finish_test("random_order");
      run_blocking();
      finish_test("blocking");
      bp_mode <= 2'd3;
      repeat (2) @(posedge clk);
      send_table(1'b1);
      wait_drained(1'b1);
      bp_mode <= 2'd0;
      finish_test("resp_only");
      $display("Tests run %0d, errors %0d", tests_run, tb_errors + chk_errors);
      if (tb_errors + chk_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
